//--- bch_syndrome.f
+incdir+rtl
+incdir+tests
rtl/gf16_pkg.sv
rtl/bch_pkg.sv
rtl/bch_sequencer.sv
rtl/bch_encoder.sv
rtl/bch_syndrome_unit.sv
rtl/bch_result_reg.sv
rtl/bch_syndrome_top.sv
tests/bch_syndrome_tb.sv

//--- rtl/bch_defs.svh
`ifndef BCH_DEFS_SVH
`define BCH_DEFS_SVH

// ------------------------------------------------------------
// code geometry
// ------------------------------------------------------------

`define BCH_N         15    // codeword length
`define BCH_K         7     // message length
`define BCH_M         4     // GF(2^m) degree
`define BCH_NSYN      4     // syndromes S1..S4, enough for t = 2

// ------------------------------------------------------------
// polynomials
// ------------------------------------------------------------

// g(x) = x^8 + x^7 + x^6 + x^4 + 1
`define BCH_GEN_POLY  9'b1_1101_0001

// p(x) = x^4 + x + 1, alpha is a root
`define BCH_PRIM_POLY 5'b1_0011

`endif

//--- rtl/bch_encoder.sv
`timescale 1ns/1ns

`include "bch_defs.svh"

module bch_encoder
(
    input  logic               clk,
    input  logic               rst,
    input  logic               encode_en,
    input  bch_pkg::msg_t      msg_q,
    output bch_pkg::codeword_t codeword
);

    import bch_pkg::*;

    codeword_t product;

    // c(x) = m(x) * g(x) over GF(2)
    always_comb
    begin
        product = '0;
        for (int i = 0; i < `BCH_K; i++)
        begin
            if (msg_q[i])
                product = product ^ (codeword_t'(`BCH_GEN_POLY) << i);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            codeword <= '0;
        else if (encode_en)
            codeword <= product;    // one cycle in ENCODE
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // message captured by the sequencer must be known by now
    codeword_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(codeword));

endmodule

//--- rtl/bch_pkg.sv
`include "bch_defs.svh"

package bch_pkg;

    // ------------------------------------------------------------
    // data words
    // ------------------------------------------------------------

    typedef logic [`BCH_K-1:0] msg_t;         // bit i is coefficient of x^i
    typedef logic [`BCH_N-1:0] codeword_t;    // codeword, received word, mask

    // S1 in [3:0], S2 in [7:4], and so on
    typedef logic [`BCH_NSYN*`BCH_M-1:0] syndrome_set_t;

    typedef logic [$clog2(`BCH_NSYN)-1:0] syn_index_t;

    // ------------------------------------------------------------
    // sequencer states
    // ------------------------------------------------------------

    typedef enum logic [2:0]
    {
        IDLE     = 3'h0,
        ENCODE   = 3'h1,
        CHANNEL  = 3'h2,    // codeword xor mask
        SYNDROME = 3'h3,
        REPORT   = 3'h4
    } seq_state_t;

endpackage

//--- rtl/bch_result_reg.sv
`timescale 1ns/1ns

`include "bch_defs.svh"

module bch_result_reg
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   report_en,
    input  bch_pkg::codeword_t     codeword,
    input  bch_pkg::syndrome_set_t syndromes,
    output bch_pkg::codeword_t     codeword_out,
    output bch_pkg::syndrome_set_t syndromes_out,
    output logic                   error_detected,
    output logic                   done
);

    import bch_pkg::*;
    import gf16_pkg::*;

    gf_elem_t s1;
    gf_elem_t s2;
    gf_elem_t s4;

    assign s1 = syndromes[0*`BCH_M +: `BCH_M];
    assign s2 = syndromes[1*`BCH_M +: `BCH_M];
    assign s4 = syndromes[3*`BCH_M +: `BCH_M];

    // outputs hold until the next report
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            codeword_out   <= '0;
            syndromes_out  <= '0;
            error_detected <= 1'b0;
        end
        else if (report_en)
        begin
            codeword_out   <= codeword;
            syndromes_out  <= syndromes;
            error_detected <= |syndromes;   // any S_j nonzero
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            done <= 1'b0;
        else
            done <= report_en;  // single pulse, REPORT lasts one cycle
    end

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // binary code, so S_2j = S_j^2 for whatever the syndrome unit produced
    even_syndromes: assert property (@(posedge clk) disable iff (rst)
        report_en |-> (gf_mul(s1, s1) == s2) && (gf_mul(s2, s2) == s4));

endmodule

//--- rtl/bch_sequencer.sv
`timescale 1ns/1ns

module bch_sequencer
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  bch_pkg::msg_t      msg,
    input  bch_pkg::codeword_t error_mask,
    input  logic               syn_last,
    output bch_pkg::msg_t      msg_q,
    output bch_pkg::codeword_t mask_q,
    output logic               encode_en,
    output logic               channel_en,
    output logic               synd_en,
    output logic               report_en,
    output logic               busy
);

    import bch_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;

    // capture the job only when idle, a start while busy is dropped
    always_ff @(posedge clk)
    begin
        if (state == IDLE && start)
        begin
            msg_q  <= msg;
            mask_q <= error_mask;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            IDLE:     if (start) state_nxt = ENCODE;
            ENCODE:   state_nxt = CHANNEL;
            CHANNEL:  state_nxt = SYNDROME;
            SYNDROME: if (syn_last) state_nxt = REPORT;   // after S4
            REPORT:   state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // stage strobes, levels for the whole state
    assign encode_en  = (state == ENCODE);
    assign channel_en = (state == CHANNEL);
    assign synd_en    = (state == SYNDROME);
    assign report_en  = (state == REPORT);
    assign busy       = (state != IDLE);

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    idle_needs_start: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE && !start) |=> (state == IDLE));

    report_one_cycle: assert property (@(posedge clk) disable iff (rst)
        (state == REPORT) |=> (state == IDLE));

endmodule

//--- rtl/bch_syndrome_top.sv
`timescale 1ns/1ns

module bch_syndrome_top
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  bch_pkg::msg_t          msg,
    input  bch_pkg::codeword_t     error_mask,
    output bch_pkg::codeword_t     codeword,
    output bch_pkg::syndrome_set_t syndromes,
    output logic                   error_detected,
    output logic                   done,
    output logic                   busy
);

    import bch_pkg::*;

    msg_t          msg_q;
    codeword_t     mask_q;
    codeword_t     enc_codeword;    // encoder output, before the channel
    syndrome_set_t syn_set;
    logic          encode_en;
    logic          channel_en;
    logic          synd_en;
    logic          report_en;
    logic          syn_last;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------

    bch_sequencer bch_sequencer_i
    (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .msg        (msg),
        .error_mask (error_mask),
        .syn_last   (syn_last),
        .msg_q      (msg_q),
        .mask_q     (mask_q),
        .encode_en  (encode_en),
        .channel_en (channel_en),
        .synd_en    (synd_en),
        .report_en  (report_en),
        .busy       (busy)
    );

    // ------------------------------------------------------------
    // data path
    // ------------------------------------------------------------

    bch_encoder bch_encoder_i
    (
        .clk       (clk),
        .rst       (rst),
        .encode_en (encode_en),
        .msg_q     (msg_q),
        .codeword  (enc_codeword)
    );

    bch_syndrome_unit bch_syndrome_unit_i
    (
        .clk        (clk),
        .rst        (rst),
        .channel_en (channel_en),
        .synd_en    (synd_en),
        .codeword   (enc_codeword),
        .mask_q     (mask_q),
        .syndromes  (syn_set),
        .syn_last   (syn_last)
    );

    bch_result_reg bch_result_reg_i
    (
        .clk            (clk),
        .rst            (rst),
        .report_en      (report_en),
        .codeword       (enc_codeword),
        .syndromes      (syn_set),
        .codeword_out   (codeword),
        .syndromes_out  (syndromes),
        .error_detected (error_detected),
        .done           (done)
    );

endmodule

//--- rtl/bch_syndrome_unit.sv
`timescale 1ns/1ns

`include "bch_defs.svh"

module bch_syndrome_unit
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   channel_en,
    input  logic                   synd_en,
    input  bch_pkg::codeword_t     codeword,
    input  bch_pkg::codeword_t     mask_q,
    output bch_pkg::syndrome_set_t syndromes,
    output logic                   syn_last
);

    import bch_pkg::*;
    import gf16_pkg::*;

    codeword_t  received;
    syn_index_t syn_idx;
    gf_elem_t   syn_value;

    // ------------------------------------------------------------
    // channel, injects the requested error pattern
    // ------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (channel_en)
            received <= codeword ^ mask_q;
    end

    // ------------------------------------------------------------
    // syndrome evaluation, S_j = r(alpha^j)
    // ------------------------------------------------------------

    always_comb
    begin
        syn_value = '0;
        for (int unsigned i = 0; i < `BCH_N; i++)
        begin
            if (received[i])
                syn_value = syn_value ^ gf_alpha_pow(i * (int'(syn_idx) + 1));
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            syn_idx <= '0;
        else if (channel_en)
            syn_idx <= '0;              // restart at S1
        else if (synd_en)
            syn_idx <= syn_idx + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (synd_en)
            syndromes[int'(syn_idx)*`BCH_M +: `BCH_M] <= syn_value;
    end

    // tells the sequencer that S4 is on this edge
    assign syn_last = synd_en && (syn_idx == syn_index_t'(`BCH_NSYN - 1));

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    // a fifth syndrome cycle would overwrite S1
    no_overrun: assert property (@(posedge clk) disable iff (rst)
        syn_last |=> !synd_en);

endmodule

//--- rtl/gf16_pkg.sv
`include "bch_defs.svh"

package gf16_pkg;

    // one field element, polynomial basis, bit k is coefficient of alpha^k
    typedef logic [`BCH_M-1:0] gf_elem_t;

    // multiply by x, then reduce by the field polynomial
    function automatic gf_elem_t gf_mul_x(input gf_elem_t a);
        logic [`BCH_M:0] t;
        t = {a, 1'b0};
        if (t[`BCH_M])
            t = t ^ `BCH_PRIM_POLY;
        return t[`BCH_M-1:0];
    endfunction

    // shift-and-add product in GF(16)
    function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
        gf_elem_t acc;
        gf_elem_t sh;
        acc = '0;
        sh  = a;
        for (int k = 0; k < `BCH_M; k++)
        begin
            if (b[k])
                acc = acc ^ sh;
            sh = gf_mul_x(sh);
        end
        return acc;
    endfunction

    // alpha^e, exponent folded into 0..14 first
    function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
        int unsigned r;
        gf_elem_t    p;
        gf_elem_t    res;
        r   = e % ((1 << `BCH_M) - 1);
        p   = gf_elem_t'(1);
        res = gf_elem_t'(1);
        for (int unsigned k = 0; k < (1 << `BCH_M) - 1; k++)
        begin
            if (k == r)
                res = p;
            p = gf_mul_x(p);    // walk the power table
        end
        return res;
    endfunction

endpackage

//--- tests/bch_ref_model.svh
`ifndef BCH_REF_MODEL_SVH
`define BCH_REF_MODEL_SVH

`include "bch_defs.svh"

// c(x) = m(x) * g(x), generator shifted once per message bit
function automatic logic [`BCH_N-1:0] ref_encode(input logic [`BCH_K-1:0] m);
    logic [`BCH_N-1:0] c;
    logic [`BCH_N-1:0] g;
    c = '0;
    g = `BCH_GEN_POLY;
    for (int i = 0; i < `BCH_K; i++)
    begin
        if (m[i])
            c = c ^ g;
        g = g << 1;
    end
    return c;
endfunction

// alpha^e by stepping x^k, reduced with x^4 + x + 1
function automatic logic [`BCH_M-1:0] ref_alpha_pow(input int e);
    logic [`BCH_M-1:0] p;
    logic [`BCH_M:0]   poly;
    int                n;
    poly = `BCH_PRIM_POLY;
    n    = e % 15;
    p    = 1;
    for (int k = 0; k < n; k++)
    begin
        if (p[`BCH_M-1])
            p = {p[`BCH_M-2:0], 1'b0} ^ poly[`BCH_M-1:0];
        else
            p = {p[`BCH_M-2:0], 1'b0};
    end
    return p;
endfunction

// S_j = r(alpha^j) for j = 1..4, S1 in the low nibble
function automatic logic [`BCH_NSYN*`BCH_M-1:0] ref_syndromes(input logic [`BCH_N-1:0] r);
    logic [`BCH_NSYN*`BCH_M-1:0] s;
    logic [`BCH_M-1:0]           sj;
    s = '0;
    for (int j = 1; j <= `BCH_NSYN; j++)
    begin
        sj = '0;
        for (int i = 0; i < `BCH_N; i++)
        begin
            if (r[i])
                sj = sj ^ ref_alpha_pow(i * j);
        end
        s[(j-1)*`BCH_M +: `BCH_M] = sj;
    end
    return s;
endfunction

`endif

//--- tests/bch_syndrome_tb.sv
`timescale 1ns/1ns

`include "bch_defs.svh"

module bch_syndrome_tb;

    import bch_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int DONE_LATENCY   = 7;     // E0 to E7

    logic          clk;
    logic          rst;
    logic          start;
    msg_t          msg;
    codeword_t     error_mask;
    codeword_t     codeword;
    syndrome_set_t syndromes;
    logic          error_detected;
    logic          done;
    logic          busy;

    integer seed;
    int     errors       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     cycle_cnt    = 0;

    // expected results of the jobs in flight in start order
    string         exp_name[$];
    codeword_t     exp_cw[$];
    syndrome_set_t exp_syn[$];
    logic          exp_err[$];
    int            exp_edge[$];

    `include "bch_ref_model.svh"

    bch_syndrome_top bch_syndrome_top_i
    (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .msg            (msg),
        .error_mask     (error_mask),
        .codeword       (codeword),
        .syndromes      (syndromes),
        .error_detected (error_detected),
        .done           (done),
        .busy           (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;     // number of rising edges so far

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAILED %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    // one start pulse and a wait until the DUT is idle again
    task automatic run_job(input string name, input msg_t m, input codeword_t mask,
                           input syndrome_set_t syn, input bit poke);
        int busy_cycles;
        busy_cycles = 0;
        @(negedge clk);
        start      = 1'b1;
        msg        = m;
        error_mask = mask;
        exp_name.push_back(name);
        exp_cw.push_back(ref_encode(m));
        exp_syn.push_back(syn);
        exp_err.push_back(mask != '0);  // weight 2 or less is always seen
        exp_edge.push_back(cycle_cnt + 1);
        @(negedge clk);
        start = 1'b0;
        while (busy && busy_cycles < TIMEOUT_CYCLES)
        begin
            busy_cycles++;
            if (poke && busy_cycles == 3)
            begin
                start      = 1'b1;      // second start while busy
                msg        = ~m;
                error_mask = ~mask;
            end
            if (poke && busy_cycles == 4)
                start = 1'b0;
            @(negedge clk);
        end
        if (busy)
            abort_run("busy to fall");
        else
            check({name, " busy cycles"}, DONE_LATENCY, busy_cycles);
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial
    begin : stimulus
        msg_t          m;
        codeword_t     mask;
        syndrome_set_t syn;
        int            bit_a;
        int            bit_b;
        int            waited;
        int            errors_before;
        seed       = 32'hb2716156;
        rst        = 1'b1;
        start      = 1'b0;
        msg        = '0;
        error_mask = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        errors_before = errors;
        check("reset done", 0, done);
        check("reset busy", 0, busy);
        check("reset error_detected", 0, error_detected);
        check("reset codeword", 0, codeword);
        check("reset syndromes", 0, syndromes);
        tests_run++;
        if (errors != errors_before)
        begin
            tests_failed++;
            $display("%-20s mismatch", "reset_state");
        end
        else
            $display("%-20s ok", "reset_state");

        for (int v = 0; v < 128; v++)
            run_job($sformatf("clean_%02h", v), msg_t'(v), '0, '0, 1'b0);

        for (int t = 0; t < 8; t++)
        begin
            m     = $random(seed);
            bit_a = $unsigned($random(seed)) % `BCH_N;
            mask  = codeword_t'(1) << bit_a;
            syn   = '0;
            for (int j = 1; j <= `BCH_NSYN; j++)
                syn[(j-1)*`BCH_M +: `BCH_M] = ref_alpha_pow(bit_a * j);
            run_job($sformatf("single_%0d_bit%0d", t, bit_a), m, mask, syn, 1'b0);
        end

        for (int t = 0; t < 8; t++)
        begin
            m     = $random(seed);
            bit_a = $unsigned($random(seed)) % `BCH_N;
            bit_b = (bit_a + 1 + $unsigned($random(seed)) % (`BCH_N - 1)) % `BCH_N;
            mask  = (codeword_t'(1) << bit_a) | (codeword_t'(1) << bit_b);
            syn   = ref_syndromes(ref_encode(m) ^ mask);
            run_job($sformatf("double_%0d", t), m, mask, syn, 1'b0);
        end

        m = $random(seed);
        run_job("timing_busy_start", m, '0, '0, 1'b1);

        waited = 0;
        while (exp_name.size() > 0 && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_name.size() > 0)
            abort_run("last done");
        else
        begin
            repeat (12) @(negedge clk);     // a stray done would show up here

            $display("%0d tests, %0d failed, %0d check errors",
                     tests_run, tests_failed, errors);
            if (errors == 0)
                $display("Test passed");
            else
                $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // comparison
    // ------------------------------------------------------------

    initial
    begin : compare
        int    waited;
        int    errors_before;
        string name;
        forever
        begin
            @(negedge clk);
            if (done && exp_name.size() == 0)
            begin
                $display("done pulsed with no job in flight");
                errors++;
            end
            else if (exp_name.size() > 0)
            begin
                waited = 0;
                while (!done && waited < TIMEOUT_CYCLES)
                begin
                    @(negedge clk);
                    waited++;
                end
                if (!done)
                    abort_run("done");
                else
                begin
                    errors_before = errors;
                    name          = exp_name.pop_front();
                    check({name, " latency"}, DONE_LATENCY,
                          cycle_cnt - exp_edge.pop_front());
                    check({name, " codeword"}, exp_cw.pop_front(), codeword);
                    check({name, " syndromes"}, exp_syn.pop_front(), syndromes);
                    check({name, " error_detected"}, exp_err.pop_front(), error_detected);
                    @(negedge clk);
                    check({name, " done width"}, 0, done);     // one cycle only
                    tests_run++;
                    if (errors != errors_before)
                    begin
                        tests_failed++;
                        $display("%-20s mismatch", name);
                    end
                    else
                        $display("%-20s ok", name);
                end
            end
        end
    end

endmodule
